// File: Makefile
# Verilator build and run of the loopback engine testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_nlb_lpbk \
		-f verilog.f -o sim_nlb
	./obj_dir/sim_nlb | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: nlb_csr.sv
// MMIO register file of the loopback engine. Holds the test setup,
// forms the test reset and start pulse, locks the setup while a test
// runs and returns status and counters with a one-cycle read latency.
`timescale 1ns/10ps

module nlb_csr #(
   parameter int ADDR_LMT = nlb_pkg::ADDR_LMT
) (
   input  logic                            Clk_400,
   input  logic                            reset,
   // MMIO request side
   input  logic                            mmio_wr_en,
   input  logic                            mmio_rd_en,
   input  logic [nlb_pkg::MMIO_ADDR_W-1:0] mmio_addr,
   input  logic [nlb_pkg::MMIO_DATA_W-1:0] mmio_wdata,
   // MMIO read response
   output logic                            mmio_rd_valid,
   output logic [nlb_pkg::MMIO_DATA_W-1:0] mmio_rdata,
   // Test setup toward the engine
   output logic                            test_rst,
   output logic                            go,
   output logic [ADDR_LMT-1:0]             src_addr,
   output logic [ADDR_LMT-1:0]             dst_addr,
   output logic [31:0]                     num_lines,
   output nlb_pkg::t_test_mode             mode,
   // Status back from engine and requester
   input  logic                            running,
   input  logic                            done,
   input  logic [31:0]                     num_reads,
   input  logic [31:0]                     num_writes
);

   localparam int DW = nlb_pkg::MMIO_DATA_W;

   logic [DW-1:0] scratch;
   logic          ctl_rst_n;
   logic          ctl_start;
   // Start bit as seen one clock earlier
   logic          start_prev;
   logic [DW-1:0] rd_mux;

   // -------------------------------------------------------------------
   // Register writes
   // -------------------------------------------------------------------
   always_ff @(posedge Clk_400)
   begin
      if (reset)
      begin
         scratch    <= '0;
         src_addr   <= '0;
         dst_addr   <= '0;
         num_lines  <= '0;
         mode       <= nlb_pkg::M_LPBK1;
         ctl_rst_n  <= 1'b0;
         ctl_start  <= 1'b0;
         start_prev <= 1'b0;
      end
      else
      begin
         start_prev <= ctl_start;
         if (mmio_wr_en)
         begin
            case (mmio_addr)
               nlb_pkg::CSR_SCRATCH:   scratch <= mmio_wdata;
               // Setup registers are frozen while the engine runs
               nlb_pkg::CSR_SRC_ADDR:  if (!running) src_addr  <= mmio_wdata[ADDR_LMT-1:0];
               nlb_pkg::CSR_DST_ADDR:  if (!running) dst_addr  <= mmio_wdata[ADDR_LMT-1:0];
               nlb_pkg::CSR_NUM_LINES: if (!running) num_lines <= mmio_wdata[31:0];
               nlb_pkg::CSR_CFG:
                  if (!running)
                     mode <= nlb_pkg::t_test_mode'(mmio_wdata[nlb_pkg::CFG_MODE_LSB +: 3]);
               // Control word is always writable so a test can be reset
               nlb_pkg::CSR_CTL:
               begin
                  ctl_rst_n <= mmio_wdata[nlb_pkg::CTL_RST_N_BIT];
                  ctl_start <= mmio_wdata[nlb_pkg::CTL_START_BIT];
               end
               default: ;
            endcase
         end
      end
   end

   // Test reset follows the active-low control bit
   assign test_rst = ~ctl_rst_n;
   // Rising start bit out of test reset launches one run
   assign go = ctl_rst_n & ctl_start & ~start_prev;

   // -------------------------------------------------------------------
   // Read-back
   // -------------------------------------------------------------------
   always_comb
   begin
      rd_mux = '0;
      case (mmio_addr)
         nlb_pkg::CSR_SCRATCH:    rd_mux = scratch;
         nlb_pkg::CSR_SRC_ADDR:   rd_mux[ADDR_LMT-1:0] = src_addr;
         nlb_pkg::CSR_DST_ADDR:   rd_mux[ADDR_LMT-1:0] = dst_addr;
         nlb_pkg::CSR_NUM_LINES:  rd_mux[31:0] = num_lines;
         nlb_pkg::CSR_CTL:
         begin
            rd_mux[nlb_pkg::CTL_RST_N_BIT] = ctl_rst_n;
            rd_mux[nlb_pkg::CTL_START_BIT] = ctl_start;
         end
         nlb_pkg::CSR_CFG:        rd_mux[nlb_pkg::CFG_MODE_LSB +: 3] = mode;
         // Bit 0 is the completion flag that software polls
         nlb_pkg::CSR_STATUS:     rd_mux[0] = done;
         nlb_pkg::CSR_NUM_READS:  rd_mux[31:0] = num_reads;
         nlb_pkg::CSR_NUM_WRITES: rd_mux[31:0] = num_writes;
         default: ;   // unmapped reads return zero
      endcase
   end

   // Response one clock after the read request
   always_ff @(posedge Clk_400)
   begin
      if (reset)
      begin
         mmio_rd_valid <= 1'b0;
         mmio_rdata    <= '0;
      end
      else
      begin
         mmio_rd_valid <= mmio_rd_en;
         if (mmio_rd_en)
            mmio_rdata <= rd_mux;
      end
   end

endmodule

// File: nlb_lpbk.sv
// Top level of the native loopback test engine. Connects the CSR block,
// the test engine and the memory requester and sets their widths.
`timescale 1ns/10ps

module nlb_lpbk #(
   parameter int ADDR_LMT   = nlb_pkg::ADDR_LMT,
   parameter int DATA_WIDTH = nlb_pkg::DATA_WIDTH_DEF
) (
   input  logic                            Clk_400,
   input  logic                            reset,
   // MMIO port
   input  logic                            mmio_wr_en,
   input  logic                            mmio_rd_en,
   input  logic [nlb_pkg::MMIO_ADDR_W-1:0] mmio_addr,
   input  logic [nlb_pkg::MMIO_DATA_W-1:0] mmio_wdata,
   output logic                            mmio_rd_valid,
   output logic [nlb_pkg::MMIO_DATA_W-1:0] mmio_rdata,
   // Memory port, four-phase req/ack
   output logic                            mem_req,
   output logic                            mem_we,
   output logic [ADDR_LMT-1:0]             mem_addr,
   output logic [DATA_WIDTH-1:0]           mem_wdata,
   input  logic                            mem_ack,
   input  logic [DATA_WIDTH-1:0]           mem_rdata
);

   // CSR to engine
   logic                  test_rst;
   logic                  go;
   logic [ADDR_LMT-1:0]   src_addr;
   logic [ADDR_LMT-1:0]   dst_addr;
   logic [31:0]           num_lines;
   nlb_pkg::t_test_mode   mode;
   logic                  running;
   logic                  done;
   // Engine to requester
   logic                  cmd_start;
   logic                  cmd_we;
   logic [ADDR_LMT-1:0]   cmd_addr;
   logic [DATA_WIDTH-1:0] cmd_wdata;
   logic                  cmd_done;
   logic [DATA_WIDTH-1:0] rd_data;
   // Requester counters back to CSR
   logic [31:0]           num_reads;
   logic [31:0]           num_writes;

   nlb_csr #(
      .ADDR_LMT (ADDR_LMT)
   ) inst_nlb_csr (
      .Clk_400, .reset,
      .mmio_wr_en, .mmio_rd_en, .mmio_addr, .mmio_wdata,
      .mmio_rd_valid, .mmio_rdata,
      .test_rst, .go, .src_addr, .dst_addr, .num_lines, .mode,
      .running, .done, .num_reads, .num_writes
   );

   nlb_test_engine #(
      .ADDR_LMT   (ADDR_LMT),
      .DATA_WIDTH (DATA_WIDTH)
   ) inst_test_engine (
      .Clk_400, .reset, .test_rst,
      .go, .src_addr, .dst_addr, .num_lines, .mode,
      .running, .done,
      .cmd_start, .cmd_we, .cmd_addr, .cmd_wdata, .cmd_done, .rd_data
   );

   nlb_requestor #(
      .ADDR_LMT   (ADDR_LMT),
      .DATA_WIDTH (DATA_WIDTH)
   ) inst_requestor (
      .Clk_400, .reset, .test_rst,
      .cmd_start, .cmd_we, .cmd_addr, .cmd_wdata, .cmd_done, .rd_data,
      .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata,
      .num_reads, .num_writes
   );

endmodule

// File: nlb_lpbk_sva.sv
// Four-phase handshake checks on the memory port of the requester.
// Bound into nlb_requestor when the testbench is built.
`timescale 1ns/10ps

module nlb_lpbk_sva #(
   parameter int ADDR_LMT   = nlb_pkg::ADDR_LMT,
   parameter int DATA_WIDTH = nlb_pkg::DATA_WIDTH_DEF
) (
   input logic                  Clk_400,
   input logic                  reset,
   input logic                  mem_req,
   input logic                  mem_we,
   input logic [ADDR_LMT-1:0]   mem_addr,
   input logic [DATA_WIDTH-1:0] mem_wdata,
   input logic                  mem_ack
);

   // Request held until memory answers
   req_held: assert property (@(posedge Clk_400) disable iff (reset)
      mem_req && !mem_ack |=> mem_req)
      else $error("mem_req dropped before mem_ack");

   // Fields frozen for the whole request
   fields_stable: assert property (@(posedge Clk_400) disable iff (reset)
      mem_req |=> !mem_req || ($stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata)))
      else $error("mem_addr, mem_we or mem_wdata changed during a request");

   // No new request until ack has fallen
   no_rise_on_ack: assert property (@(posedge Clk_400) disable iff (reset)
      mem_ack && !mem_req |=> !mem_req)
      else $error("mem_req rose while mem_ack was high");

endmodule

bind nlb_requestor nlb_lpbk_sva #(
   .ADDR_LMT   (ADDR_LMT),
   .DATA_WIDTH (DATA_WIDTH)
) sva_inst (
   .Clk_400   (Clk_400),
   .reset     (reset),
   .mem_req   (mem_req),
   .mem_we    (mem_we),
   .mem_addr  (mem_addr),
   .mem_wdata (mem_wdata),
   .mem_ack   (mem_ack)
);

// File: nlb_pkg.sv
// Shared widths, CSR byte address map, control bit positions and the
// mode and state encodings of the native loopback engine.
// Modules refer to these as nlb_pkg::name.

package nlb_pkg;

   // -------------------------------------------------------------------
   // Widths
   // -------------------------------------------------------------------
   // Default cache line address width
   localparam int ADDR_LMT       = 20;
   // Default cache line data width
   localparam int DATA_WIDTH_DEF = 64;
   localparam int MMIO_ADDR_W    = 16;
   localparam int MMIO_DATA_W    = 64;

   // -------------------------------------------------------------------
   // CSR byte addresses
   // -------------------------------------------------------------------
   localparam logic [MMIO_ADDR_W-1:0] CSR_SCRATCH    = 16'h0100;
   localparam logic [MMIO_ADDR_W-1:0] CSR_SRC_ADDR   = 16'h0120;
   localparam logic [MMIO_ADDR_W-1:0] CSR_DST_ADDR   = 16'h0128;
   localparam logic [MMIO_ADDR_W-1:0] CSR_NUM_LINES  = 16'h0130;
   localparam logic [MMIO_ADDR_W-1:0] CSR_CTL        = 16'h0138;
   localparam logic [MMIO_ADDR_W-1:0] CSR_CFG        = 16'h0140;
   // Read-only block
   localparam logic [MMIO_ADDR_W-1:0] CSR_STATUS     = 16'h0160;
   localparam logic [MMIO_ADDR_W-1:0] CSR_NUM_READS  = 16'h0168;
   localparam logic [MMIO_ADDR_W-1:0] CSR_NUM_WRITES = 16'h0170;

   // Control word fields, active-low test reset and start
   localparam int CTL_RST_N_BIT = 0;
   localparam int CTL_START_BIT = 1;
   // Mode field is three bits wide starting here
   localparam int CFG_MODE_LSB  = 2;

   // -------------------------------------------------------------------
   // Encodings
   // -------------------------------------------------------------------
   // Test mode opcodes, other values are unsupported
   typedef enum logic [2:0] {
      M_LPBK1 = 3'd0,
      M_READ  = 3'd1,
      M_WRITE = 3'd2
   } t_test_mode;

   // Engine FSM states
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_READ,
      ST_WRITE,
      ST_DONE
   } t_engine_state;

endpackage

// File: nlb_requestor.sv
// Memory requester of the loopback engine. Takes one command at a time
// from the engine, runs the four-phase req/ack handshake, keeps read
// data and counts completed reads and writes.
`timescale 1ns/10ps

module nlb_requestor #(
   parameter int ADDR_LMT   = nlb_pkg::ADDR_LMT,
   parameter int DATA_WIDTH = nlb_pkg::DATA_WIDTH_DEF
) (
   input  logic                  Clk_400,
   input  logic                  reset,
   input  logic                  test_rst,
   // Command from the engine
   input  logic                  cmd_start,
   input  logic                  cmd_we,
   input  logic [ADDR_LMT-1:0]   cmd_addr,
   input  logic [DATA_WIDTH-1:0] cmd_wdata,
   output logic                  cmd_done,
   output logic [DATA_WIDTH-1:0] rd_data,
   // Memory port
   output logic                  mem_req,
   output logic                  mem_we,
   output logic [ADDR_LMT-1:0]   mem_addr,
   output logic [DATA_WIDTH-1:0] mem_wdata,
   input  logic                  mem_ack,
   input  logic [DATA_WIDTH-1:0] mem_rdata,
   // Completion counters
   output logic [31:0]           num_reads,
   output logic [31:0]           num_writes
);

   // Phase 3 done, waiting for memory to drop ack
   logic wait_fall;
   logic accept;
   logic ack_rise;
   logic complete;

   // New command only when the handshake is fully idle
   assign accept   = cmd_start & ~mem_req & ~wait_fall;
   assign ack_rise = mem_req & mem_ack;
   // Phase 4 seen, request retired
   assign complete = wait_fall & ~mem_ack;

   // -------------------------------------------------------------------
   // Handshake control
   // -------------------------------------------------------------------
   always_ff @(posedge Clk_400)
   begin
      if (reset)
      begin
         mem_req   <= 1'b0;
         wait_fall <= 1'b0;
         cmd_done  <= 1'b0;
      end
      else
      begin
         cmd_done <= complete;
         if (accept)
            mem_req <= 1'b1;
         // Drop req once memory answers
         if (ack_rise)
         begin
            mem_req   <= 1'b0;
            wait_fall <= 1'b1;
         end
         if (complete)
            wait_fall <= 1'b0;
      end
   end

   // Request fields, held for the whole handshake
   always_ff @(posedge Clk_400)
   begin
      if (reset)
      begin
         mem_we    <= 1'b0;
         mem_addr  <= '0;
         mem_wdata <= '0;
         rd_data   <= '0;
      end
      else
      begin
         if (accept)
         begin
            mem_we    <= cmd_we;
            mem_addr  <= cmd_addr;
            mem_wdata <= cmd_wdata;
         end
         // Read data is only valid while ack is high
         if (ack_rise && !mem_we)
            rd_data <= mem_rdata;
      end
   end

   // -------------------------------------------------------------------
   // Counters, cleared by reset or test reset
   // -------------------------------------------------------------------
   always_ff @(posedge Clk_400)
   begin
      if (reset || test_rst)
      begin
         num_reads  <= '0;
         num_writes <= '0;
      end
      else if (complete)
      begin
         if (mem_we)
            num_writes <= num_writes + 32'd1;
         else
            num_reads <= num_reads + 32'd1;
      end
   end

endmodule

// File: nlb_test_engine.sv
// Test engine FSM. Walks the line index from 0 to num_lines - 1 and
// hands read or write commands to the requester, one at a time, in
// the order the selected mode needs.
`timescale 1ns/10ps

module nlb_test_engine #(
   parameter int ADDR_LMT   = nlb_pkg::ADDR_LMT,
   parameter int DATA_WIDTH = nlb_pkg::DATA_WIDTH_DEF
) (
   input  logic                  Clk_400,
   input  logic                  reset,
   input  logic                  test_rst,
   // Test setup from the CSR block
   input  logic                  go,
   input  logic [ADDR_LMT-1:0]   src_addr,
   input  logic [ADDR_LMT-1:0]   dst_addr,
   input  logic [31:0]           num_lines,
   input  nlb_pkg::t_test_mode   mode,
   output logic                  running,
   output logic                  done,
   // Command toward the requester
   output logic                  cmd_start,
   output logic                  cmd_we,
   output logic [ADDR_LMT-1:0]   cmd_addr,
   output logic [DATA_WIDTH-1:0] cmd_wdata,
   input  logic                  cmd_done,
   input  logic [DATA_WIDTH-1:0] rd_data
);

   nlb_pkg::t_engine_state state;
   nlb_pkg::t_engine_state state_nxt;

   logic [31:0]           idx;
   logic [31:0]           idx_nxt;
   logic                  last_line;
   logic                  mode_ok;
   // Line addresses for the current and the next index, modulo 2^ADDR_LMT
   logic [ADDR_LMT-1:0]   src_line;
   logic [ADDR_LMT-1:0]   dst_line;
   logic [ADDR_LMT-1:0]   src_nxt;
   logic [ADDR_LMT-1:0]   dst_nxt;
   // Next command and index step
   logic                  issue;
   logic                  step;
   logic                  iss_we;
   logic [ADDR_LMT-1:0]   iss_addr;
   logic [DATA_WIDTH-1:0] iss_wdata;

   assign idx_nxt   = idx + 32'd1;
   assign last_line = (idx_nxt == num_lines);
   assign mode_ok   = (mode == nlb_pkg::M_LPBK1) || (mode == nlb_pkg::M_READ) ||
                      (mode == nlb_pkg::M_WRITE);
   assign src_line  = src_addr + ADDR_LMT'(idx);
   assign dst_line  = dst_addr + ADDR_LMT'(idx);
   assign src_nxt   = src_addr + ADDR_LMT'(idx_nxt);
   assign dst_nxt   = dst_addr + ADDR_LMT'(idx_nxt);

   // -------------------------------------------------------------------
   // Next state and next command
   // -------------------------------------------------------------------
   always_comb
   begin
      state_nxt = state;
      issue     = 1'b0;
      step      = 1'b0;
      iss_we    = 1'b0;
      iss_addr  = src_line;
      iss_wdata = rd_data;
      case (state)
         nlb_pkg::ST_IDLE:
            if (go)
            begin
               // Nothing to do, finish at once
               if (num_lines == 32'd0 || !mode_ok)
                  state_nxt = nlb_pkg::ST_DONE;
               else if (mode == nlb_pkg::M_WRITE)
               begin
                  state_nxt = nlb_pkg::ST_WRITE;
                  issue     = 1'b1;
                  iss_we    = 1'b1;
                  iss_addr  = dst_line;
                  iss_wdata = DATA_WIDTH'(dst_line);
               end
               else
               begin
                  state_nxt = nlb_pkg::ST_READ;
                  issue     = 1'b1;
               end
            end
         nlb_pkg::ST_READ:
            if (cmd_done)
            begin
               // LPBK1 copies the line just read to the destination
               if (mode == nlb_pkg::M_LPBK1)
               begin
                  state_nxt = nlb_pkg::ST_WRITE;
                  issue     = 1'b1;
                  iss_we    = 1'b1;
                  iss_addr  = dst_line;
               end
               else
               begin
                  step = 1'b1;
                  if (last_line)
                     state_nxt = nlb_pkg::ST_DONE;
                  else
                  begin
                     issue    = 1'b1;
                     iss_addr = src_nxt;
                  end
               end
            end
         nlb_pkg::ST_WRITE:
            if (cmd_done)
            begin
               step = 1'b1;
               if (last_line)
                  state_nxt = nlb_pkg::ST_DONE;
               else if (mode == nlb_pkg::M_LPBK1)
               begin
                  state_nxt = nlb_pkg::ST_READ;
                  issue     = 1'b1;
                  iss_addr  = src_nxt;
               end
               else
               begin
                  // WRITE pattern is the line's own address
                  issue     = 1'b1;
                  iss_we    = 1'b1;
                  iss_addr  = dst_nxt;
                  iss_wdata = DATA_WIDTH'(dst_nxt);
               end
            end
         // Stays done until test reset
         default: ;
      endcase
   end

   // -------------------------------------------------------------------
   // State registers
   // -------------------------------------------------------------------
   always_ff @(posedge Clk_400)
   begin
      if (reset || test_rst)
      begin
         state     <= nlb_pkg::ST_IDLE;
         idx       <= '0;
         running   <= 1'b0;
         done      <= 1'b0;
         cmd_start <= 1'b0;
      end
      else
      begin
         state     <= state_nxt;
         cmd_start <= issue;
         if (step)
            idx <= idx_nxt;
         running <= (state_nxt == nlb_pkg::ST_READ) || (state_nxt == nlb_pkg::ST_WRITE);
         done    <= (state_nxt == nlb_pkg::ST_DONE);
      end
   end

   // Command fields change only with a new command
   always_ff @(posedge Clk_400)
   begin
      if (reset)
      begin
         cmd_we    <= 1'b0;
         cmd_addr  <= '0;
         cmd_wdata <= '0;
      end
      else if (issue)
      begin
         cmd_we    <= iss_we;
         cmd_addr  <= iss_addr;
         cmd_wdata <= iss_wdata;
      end
   end

endmodule

// File: tb_nlb_lpbk.sv
// Testbench for the native loopback engine. Drives the MMIO port from a
// table of tests, answers the memory port with a random-latency model
// and checks counters, status and memory contents after each test.
`timescale 1ns/10ps

module tb_nlb_lpbk;

   localparam int ADDR_W    = 20;
   localparam int DATA_W    = 64;
   localparam int CLK_NS    = 10;
   localparam int NUM_TESTS = 6;
   localparam logic [31:0] SEED        = 32'h1737_4d9c;
   localparam logic [63:0] SCRATCH_VAL = 64'h5a5a_0f0f_c3c3_9669;

   // One test, stimulus plus expected counts
   typedef struct packed {
      logic [2:0]  mode;
      logic [19:0] src;
      logic [19:0] dst;
      logic [31:0] lines;
      logic [31:0] exp_reads;
      logic [31:0] exp_writes;
      logic        lock_chk;
   } test_row_t;

   test_row_t test_table [NUM_TESTS] = '{
      '{nlb_pkg::M_LPBK1, 20'h00010, 20'h00080, 32'd8,  32'd8,  32'd8, 1'b0},
      '{nlb_pkg::M_READ,  20'h00030, 20'h00000, 32'd5,  32'd5,  32'd0, 1'b0},
      '{nlb_pkg::M_WRITE, 20'h00000, 20'h340c0, 32'd6,  32'd0,  32'd6, 1'b0},
      // Source range wraps through the end of the model array
      '{nlb_pkg::M_LPBK1, 20'h000f8, 20'h00040, 32'd12, 32'd12, 32'd12, 1'b1},
      '{3'b111,           20'h00020, 20'h00090, 32'd4,  32'd0,  32'd0, 1'b0},
      '{nlb_pkg::M_LPBK1, 20'h00050, 20'h000a0, 32'd0,  32'd0,  32'd0, 1'b0}
   };

   logic                            Clk_400;
   logic                            reset;
   logic                            mmio_wr_en;
   logic                            mmio_rd_en;
   logic [nlb_pkg::MMIO_ADDR_W-1:0] mmio_addr;
   logic [nlb_pkg::MMIO_DATA_W-1:0] mmio_wdata;
   logic                            mmio_rd_valid;
   logic [nlb_pkg::MMIO_DATA_W-1:0] mmio_rdata;
   logic                            mem_req;
   logic                            mem_we;
   logic [ADDR_W-1:0]               mem_addr;
   logic [DATA_W-1:0]               mem_wdata;
   logic                            mem_ack;
   logic [DATA_W-1:0]               mem_rdata;

   // Memory model contents and the expected image
   logic [63:0] mem_lines [256];
   logic [63:0] exp_lines [256];
   logic [31:0] rand_state;
   int          error_count = 0;
   int          check_count = 0;

   nlb_lpbk #(
      .ADDR_LMT   (ADDR_W),
      .DATA_WIDTH (DATA_W)
   ) dut (
      .Clk_400, .reset,
      .mmio_wr_en, .mmio_rd_en, .mmio_addr, .mmio_wdata,
      .mmio_rd_valid, .mmio_rdata,
      .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
   );

   initial
   begin
      Clk_400 = 1'b0;
      forever #(CLK_NS / 2) Clk_400 = ~Clk_400;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // -------------------------------------------------------------------
   // Memory model, four-phase responder
   // -------------------------------------------------------------------
   initial
   begin : memory_model
      int delay;
      mem_ack   = 1'b0;
      mem_rdata = '0;
      forever
      begin
         @(negedge Clk_400);
         if (mem_req === 1'b1 && mem_ack == 1'b0)
         begin
            // Ack latency of 0 to 3 cycles
            rand_state = lcg_next(rand_state);
            delay = int'(rand_state[17:16]);
            repeat (delay) @(negedge Clk_400);
            if (mem_we)
               mem_lines[mem_addr[7:0]] = mem_wdata;
            else
               mem_rdata = mem_lines[mem_addr[7:0]];
            mem_ack = 1'b1;
            do
               @(negedge Clk_400);
            while (mem_req);
            // Ack may linger one more cycle after req falls
            delay = int'(rand_state[18]);
            repeat (delay) @(negedge Clk_400);
            mem_ack = 1'b0;
         end
      end
   end

   // -------------------------------------------------------------------
   // Checks and MMIO access, all called on a falling edge
   // -------------------------------------------------------------------
   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
      check_count++;
      assert (got === expected)
      else
      begin
         $display("MISMATCH %0s: got %h expected %h", name, got, expected);
         error_count++;
      end
   endtask

   task automatic mmio_write(input logic [15:0] addr, input logic [63:0] data);
      mmio_wr_en = 1'b1;
      mmio_addr  = addr;
      mmio_wdata = data;
      @(negedge Clk_400);
      mmio_wr_en = 1'b0;
   endtask

   // Response must be there exactly one cycle later
   task automatic mmio_read(input logic [15:0] addr, output logic [63:0] data);
      mmio_rd_en = 1'b1;
      mmio_addr  = addr;
      @(negedge Clk_400);
      mmio_rd_en = 1'b0;
      check_value("mmio_rd_valid", 64'(mmio_rd_valid), 64'd1);
      data = mmio_rdata;
   endtask

   task automatic wait_done();
      logic [63:0] status;
      status = '0;
      while (status[0] !== 1'b1)
         mmio_read(nlb_pkg::CSR_STATUS, status);
   endtask

   task automatic report_test(input int num, input string name, input int errs_before);
      $display("Test %0d %0s: %0s", num, name,
               (error_count == errs_before) ? "ok" : "errors");
   endtask

   // Expected memory from the mode rules, line by line in order
   task automatic update_expected(input test_row_t row);
      logic [19:0] src_line;
      logic [19:0] dst_line;
      for (int i = 0; i < int'(row.lines); i++)
      begin
         src_line = row.src + 20'(i);
         dst_line = row.dst + 20'(i);
         case (row.mode)
            nlb_pkg::M_LPBK1: exp_lines[dst_line[7:0]] = exp_lines[src_line[7:0]];
            nlb_pkg::M_WRITE: exp_lines[dst_line[7:0]] = 64'(dst_line);
            default: ;
         endcase
      end
   endtask

   task automatic compare_memory();
      for (int i = 0; i < 256; i++)
         check_value($sformatf("mem_lines[%0d]", i), mem_lines[i], exp_lines[i]);
   endtask

   task automatic scratch_test();
      logic [63:0] rdata;
      int          errs_before;
      errs_before = error_count;
      // Memory port idle and cleared out of reset
      check_value("mem_req", 64'(mem_req), 64'd0);
      check_value("mem_we", 64'(mem_we), 64'd0);
      check_value("mem_addr", 64'(mem_addr), 64'd0);
      check_value("mem_wdata", mem_wdata, 64'd0);
      mmio_write(nlb_pkg::CSR_SCRATCH, SCRATCH_VAL);
      check_value("mmio_rd_valid", 64'(mmio_rd_valid), 64'd0);
      mmio_read(nlb_pkg::CSR_SCRATCH, rdata);
      check_value("mmio_rdata", rdata, SCRATCH_VAL);
      // Valid lasts one cycle only
      @(negedge Clk_400);
      check_value("mmio_rd_valid", 64'(mmio_rd_valid), 64'd0);
      // Unmapped address reads zero
      mmio_read(16'h0200, rdata);
      check_value("mmio_rdata", rdata, 64'd0);
      report_test(0, "scratchpad", errs_before);
   endtask

   task automatic run_row(input int r);
      test_row_t   row;
      logic [63:0] rdata;
      int          errs_before;
      row = test_table[r];
      errs_before = error_count;
      // Test reset pulse, then program and start
      mmio_write(nlb_pkg::CSR_CTL, 64'h0);
      mmio_write(nlb_pkg::CSR_CTL, 64'h1);
      mmio_write(nlb_pkg::CSR_SRC_ADDR, 64'(row.src));
      mmio_write(nlb_pkg::CSR_DST_ADDR, 64'(row.dst));
      mmio_write(nlb_pkg::CSR_NUM_LINES, 64'(row.lines));
      mmio_write(nlb_pkg::CSR_CFG, 64'(row.mode) << nlb_pkg::CFG_MODE_LSB);
      mmio_write(nlb_pkg::CSR_CTL, 64'h3);
      if (row.lock_chk)
      begin
         // Running is registered, give it one cycle to rise
         @(negedge Clk_400);
         mmio_write(nlb_pkg::CSR_NUM_LINES, 64'd3);
         mmio_read(nlb_pkg::CSR_NUM_LINES, rdata);
         check_value("num_lines", rdata, 64'(row.lines));
      end
      wait_done();
      update_expected(row);
      mmio_read(nlb_pkg::CSR_NUM_READS, rdata);
      check_value("num_reads", rdata, 64'(row.exp_reads));
      mmio_read(nlb_pkg::CSR_NUM_WRITES, rdata);
      check_value("num_writes", rdata, 64'(row.exp_writes));
      compare_memory();
      if (row.lock_chk)
      begin
         // Test reset clears status and both counters
         mmio_write(nlb_pkg::CSR_CTL, 64'h0);
         // Engine and counters clear on the clock after test reset rises
         @(negedge Clk_400);
         mmio_read(nlb_pkg::CSR_STATUS, rdata);
         check_value("status", rdata, 64'd0);
         mmio_read(nlb_pkg::CSR_NUM_READS, rdata);
         check_value("num_reads", rdata, 64'd0);
         mmio_read(nlb_pkg::CSR_NUM_WRITES, rdata);
         check_value("num_writes", rdata, 64'd0);
      end
      report_test(r + 1, $sformatf("mode %0d lines %0d", row.mode, row.lines), errs_before);
   endtask

   // -------------------------------------------------------------------
   // Main sequence
   // -------------------------------------------------------------------
   initial
   begin : main
      mmio_wr_en = 1'b0;
      mmio_rd_en = 1'b0;
      mmio_addr  = '0;
      mmio_wdata = '0;
      reset      = 1'b1;
      // Line i holds LCG step i, tagged with its index
      rand_state = SEED;
      for (int i = 0; i < 256; i++)
      begin
         rand_state   = lcg_next(rand_state);
         mem_lines[i] = {rand_state, 24'h0, 8'(i)};
         exp_lines[i] = mem_lines[i];
      end
      repeat (3) @(posedge Clk_400);
      @(negedge Clk_400);
      reset = 1'b0;
      scratch_test();
      for (int r = 0; r < NUM_TESTS; r++)
         run_row(r);
      $display("Summary: %0d tests, %0d checks, %0d errors",
               NUM_TESTS + 1, check_count, error_count);
      if (error_count == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

   // Budget of two requests of six cycles per line, plus setup time
   initial
   begin : watchdog
      longint limit_ns;
      limit_ns = 2000;
      for (int r = 0; r < NUM_TESTS; r++)
         limit_ns += longint'(test_table[r].lines) * 2 * 6 * CLK_NS;
      #(limit_ns);
      $display("Timeout: tests did not finish within %0d ns", limit_ns);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// File: verilog.f
nlb_pkg.sv
nlb_csr.sv
nlb_requestor.sv
nlb_test_engine.sv
nlb_lpbk.sv
nlb_lpbk_sva.sv
tb_nlb_lpbk.sv
